// ==== source/mult_pkg.sv ====
`default_nettype none

package mult_pkg;

    // operand width, both inputs unsigned
    localparam int operand_w = 32;

    // full product width, also the width of every tree term
    localparam int product_w = 2 * operand_w;

    // one partial product per bit of operand a
    localparam int pp_count = operand_w;

    // adder tree shape: 32 -> 8 -> 2 -> 1
    localparam int group_l1 = 4;
    localparam int group_l2 = 4;
    localparam int group_l3 = 2;

    // edges from in_vld sample to out_vld rise
    // operand reg + pp reg + three sum levels
    localparam int pipe_latency = 5;

endpackage

`default_nettype wire

// ==== source/mult_partial_products.sv ====
`default_nettype none

module mult_partial_products (
    input  logic                                            clk,
    input  logic                                            rst_n,

    // operand pair, sampled on every edge
    input  logic [mult_pkg::operand_w-1:0]                  a,
    input  logic [mult_pkg::operand_w-1:0]                  b,
    input  logic                                            in_vld,

    // registered partial products, one product_w slice per bit of a
    output logic                                            pp_vld,
    output logic [mult_pkg::pp_count*mult_pkg::product_w-1:0] pp_terms
);

    import mult_pkg::*;

    // zero padding that lifts b to the product width
    localparam int pad_w = product_w - operand_w;

    // operand stage
    logic [operand_w-1:0]          a_r;
    logic [operand_w-1:0]          b_r;
    logic                          vld_r;

    // b zero extended, shared by all shifters
    logic [product_w-1:0]          b_ext;

    // combinational partial products before the pp register
    logic [pp_count*product_w-1:0] pp_next;

    // operands load on every edge, valid is only a tag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_r <= '0;
            b_r <= '0;
        end else begin
            a_r <= a;
            b_r <= b;
        end
    end

    // valid tag for the operand stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_r <= 1'b0;
        end else begin
            vld_r <= in_vld;
        end
    end

    assign b_ext = {{pad_w{1'b0}}, b_r};

    // shift-and-gate array
    // slice i holds b << i when bit i of a is set, else zero
    // the shift never overflows, b << 31 still fits in 64 bits
    for (genvar i = 0; i < pp_count; i++) begin : g_pp
        logic [product_w-1:0] shifted;

        assign shifted = b_ext << i;

        // bit i of a selects the shifted copy
        assign pp_next[i*product_w +: product_w] = a_r[i] ? shifted : '0;
    end

    // partial product register
    // loads only behind a valid operand pair, holds otherwise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pp_terms <= '0;
        end else if (vld_r) begin
            pp_terms <= pp_next;
        end
    end

    // valid follows the operand tag by one edge
    // two edges in total from in_vld to pp_vld
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pp_vld <= 1'b0;
        end else begin
            pp_vld <= vld_r;
        end
    end

endmodule

`default_nettype wire

// ==== source/mult_sum_stage.sv ====
`default_nettype none

module mult_sum_stage #(
    // number of incoming terms
    parameter int in_count   = 32,
    // terms folded into each output sum
    parameter int group_size = 4
) (
    input  logic                                                   clk,
    input  logic                                                   rst_n,

    // incoming term bundle, term k at bits [k*product_w +: product_w]
    input  logic                                                   in_vld,
    input  logic [in_count*mult_pkg::product_w-1:0]                in_terms,

    // registered group sums, same packing as the input
    output logic                                                   out_vld,
    output logic [(in_count/group_size)*mult_pkg::product_w-1:0]   out_terms
);

    import mult_pkg::*;

    // sums produced by this level
    localparam int out_count = in_count / group_size;

    // group sums ahead of the level register
    logic [out_count*product_w-1:0] sum_next;

    // one adder chain per group of consecutive terms
    // carries out of the top bit are dropped, the true product fits anyway
    for (genvar g = 0; g < out_count; g++) begin : g_group
        logic [product_w-1:0] acc;

        always_comb begin
            acc = '0;
            // fold group_size neighbours, first term at index g*group_size
            for (int k = 0; k < group_size; k++) begin
                acc = acc + in_terms[(g*group_size+k)*product_w +: product_w];
            end
        end

        assign sum_next[g*product_w +: product_w] = acc;
    end

    // level register
    // loads only on a valid bundle, keeps the last sums otherwise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_terms <= '0;
        end else if (in_vld) begin
            out_terms <= sum_next;
        end
    end

    // valid delayed by exactly one edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vld <= 1'b0;
        end else begin
            out_vld <= in_vld;
        end
    end

endmodule

`default_nettype wire

// ==== source/mult32_pipe.sv ====
`default_nettype none

module mult32_pipe (
    input  logic                           clk,
    input  logic                           rst_n,

    // operand pair and its strobe, a new pair may come every cycle
    input  logic [mult_pkg::operand_w-1:0] a,
    input  logic [mult_pkg::operand_w-1:0] b,
    input  logic                           in_vld,

    // unsigned product, held between results
    output logic [mult_pkg::product_w-1:0] product,
    output logic                           out_vld
);

    import mult_pkg::*;

    // partial product bundle, 32 terms
    logic                                           pp_vld;
    logic [pp_count*product_w-1:0]                  pp_terms;

    // after the first level, 8 terms
    logic                                           l1_vld;
    logic [pp_count/group_l1*product_w-1:0]         l1_terms;

    // after the second level, 2 terms
    logic                                           l2_vld;
    logic [pp_count/group_l1/group_l2*product_w-1:0] l2_terms;

    // operand regs and shift-and-gate array, 2 edges
    mult_partial_products i_pp (
        .clk      (clk),
        .rst_n    (rst_n),
        .a        (a),
        .b        (b),
        .in_vld   (in_vld),
        .pp_vld   (pp_vld),
        .pp_terms (pp_terms)
    );

    // 32 to 8
    mult_sum_stage #(
        .in_count   (pp_count),
        .group_size (group_l1)
    ) i_sum_l1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_vld    (pp_vld),
        .in_terms  (pp_terms),
        .out_vld   (l1_vld),
        .out_terms (l1_terms)
    );

    // 8 to 2
    mult_sum_stage #(
        .in_count   (pp_count/group_l1),
        .group_size (group_l2)
    ) i_sum_l2 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_vld    (l1_vld),
        .in_terms  (l1_terms),
        .out_vld   (l2_vld),
        .out_terms (l2_terms)
    );

    // 2 to 1, its single term is the product
    mult_sum_stage #(
        .in_count   (pp_count/group_l1/group_l2),
        .group_size (group_l3)
    ) i_sum_l3 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_vld    (l2_vld),
        .in_terms  (l2_terms),
        .out_vld   (out_vld),
        .out_terms (product)
    );

endmodule

`default_nettype wire

// ==== bench/tb_mult32_pipe.sv ====
`default_nettype none

module tb_mult32_pipe;

    import mult_pkg::*;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 8;
    localparam int random_count = 300;
    localparam int stream_count = 40;
    // zero x random, ones x ones, one x ones, then one per bit of a
    localparam int corner_count = 3 + operand_w;
    localparam int hold_count   = 20;
    // idle cycles that flush the pipe after each phase
    localparam int drain_count  = pipe_latency + 3;
    localparam int timeout_cycles = reset_cycles + random_count + stream_count
                                  + corner_count + 1 + hold_count
                                  + 5 * drain_count + pipe_latency + 100;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic [operand_w-1:0] a;
    logic [operand_w-1:0] b;
    logic                 in_vld;
    logic [product_w-1:0] product;
    logic                 out_vld;

    integer seed = 17293;
    int     cycle_cnt = 0;
    int     error_cnt = 0;
    int     result_cnt = 0;
    int     run_len = 0;
    int     max_run = 0;

    // model queue, expected product and the cycle its in_vld was driven in
    logic [product_w-1:0] exp_q[$];
    int                   cyc_q[$];
    // value the output must hold between results
    logic [product_w-1:0] last_product = '0;

    mult32_pipe i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .a       (a),
        .b       (b),
        .in_vld  (in_vld),
        .product (product),
        .out_vld (out_vld)
    );

    always #(clk_period / 2) clk = ~clk;

    // edge k sets cycle_cnt to k
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic compare(input string name, input logic [product_w-1:0] expected,
                           input logic [product_w-1:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected %h, got %h", name, expected, actual);
            error_cnt++;
        end
    endtask

    // outputs are stable at the falling edge
    task automatic check_outputs();
        logic [product_w-1:0] exp_p;
        int                   exp_cyc;
        if (out_vld === 1'b1) begin
            run_len++;
            if (run_len > max_run) begin
                max_run = run_len;
            end
            if (exp_q.size() == 0) begin
                $display("out_vld went high while no operand pair was pending");
                error_cnt++;
            end else begin
                exp_p   = exp_q.pop_front();
                exp_cyc = cyc_q.pop_front();
                compare("product", exp_p, product);
                // result must land pipe_latency cycles after its drive cycle
                compare("out_vld cycle", exp_cyc + pipe_latency, cycle_cnt);
                result_cnt++;
            end
            last_product = product;
        end else begin
            run_len = 0;
            compare("out_vld", 1'b0, out_vld);
            // holds the last result, zero straight after reset
            compare("product", last_product, product);
        end
    endtask

    // one cycle: check what came out, then drive the next inputs
    task automatic step(input logic vld, input logic [operand_w-1:0] op_a,
                        input logic [operand_w-1:0] op_b);
        logic [product_w-1:0] model_p;
        @(negedge clk);
        check_outputs();
        a      = op_a;
        b      = op_b;
        in_vld = vld;
        if (vld) begin
            model_p = product_w'(op_a) * product_w'(op_b);
            exp_q.push_back(model_p);
            // cycle in which in_vld is driven
            cyc_q.push_back(cycle_cnt);
        end
    endtask

    // idle with junk operands, none of it may reach the output
    task automatic drain();
        repeat (drain_count) begin
            step(1'b0, $random(seed), $random(seed));
        end
    endtask

    initial begin
        rst_n  = 1'b0;
        in_vld = 1'b0;
        a      = '0;
        b      = '0;

        // reset, outputs must stay at zero
        repeat (reset_cycles) begin
            step(1'b0, '0, '0);
        end
        rst_n = 1'b1;

        // random pairs, valid about half the time
        repeat (random_count) begin
            step(1'($random(seed) & 1), $random(seed), $random(seed));
        end
        drain();

        // back to back stream
        max_run = 0;
        repeat (stream_count) begin
            step(1'b1, $random(seed), $random(seed));
        end
        drain();
        compare("out_vld run length", stream_count, max_run);

        // corner operands
        step(1'b1, '0, $random(seed));
        step(1'b1, '1, '1);
        step(1'b1, 1, '1);
        for (int i = 0; i < operand_w; i++) begin
            step(1'b1, operand_w'(1) << i, '1);
        end
        drain();

        // one result, then a long idle stretch that must not disturb it
        step(1'b1, $random(seed), $random(seed));
        repeat (hold_count) begin
            step(1'b0, $random(seed), $random(seed));
        end
        drain();

        if (exp_q.size() != 0) begin
            $display("%0d operand pairs never produced a result", exp_q.size());
            error_cnt++;
        end

        $display("%0d errors, %0d results checked", error_cnt, result_cnt);
        if (error_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog sized from the phase lengths
    initial begin
        #(timeout_cycles * clk_period);
        $display("the run timed out after %0d cycles", timeout_cycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/mult_pkg.sv
source/mult_partial_products.sv
source/mult_sum_stage.sv
source/mult32_pipe.sv
bench/tb_mult32_pipe.sv

// ==== Bender.yml ====
package:
  name: mult32_pipe

sources:
  # package first, then the stages, then the top level
  - source/mult_pkg.sv
  - source/mult_partial_products.sv
  - source/mult_sum_stage.sv
  - source/mult32_pipe.sv

  # testbench
  - target: test
    files:
      - bench/tb_mult32_pipe.sv
